// ==== Bender.yml ====
package:
  name: ntt_gf64

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/ntt_gf64_pkg.sv
      - verilog/gf64_mod_add_sub.sv
      - verilog/gf64_pow2_mult.sv
      - verilog/ntt_gf64_rdx2_col.sv
      - verilog/ntt_gf64_ntw_cst.sv
      - verilog/ntt_gf64_core.sv
  - target: test
    files:
      - tests/ntt_gf64_core_sva.sv
      - tests/ntt_gf64_core_tb.sv

// ==== include/ntt_gf64_ntw_macro.svh ====
/*
  Geometry of the hardwired networks between butterfly columns.
  From a cut number the macro derives the radix of a local group,
  the number of lanes that are interleaved per group and the number
  of independent groups in the vector.
*/
`ifndef NTT_GF64_NTW_MACRO_SVH
`define NTT_GF64_NTW_MACRO_SVH

// R_L   : radix of the local transpose
// L_NB  : stride of the transpose, grows by R with each cut
// WB_NB : independent groups over the full vector
`define NTT_GF64_NTW_LOCALPARAM(CUT_ID, RDX, N_ELT) \
  localparam int R_L   = RDX; \
  localparam int L_NB  = RDX ** (CUT_ID); \
  localparam int WB_NB = (N_ELT) / (RDX * (RDX ** (CUT_ID)));

`endif

// ==== src.f ====
+incdir+include
verilog/ntt_gf64_pkg.sv
verilog/gf64_mod_add_sub.sv
verilog/gf64_pow2_mult.sv
verilog/ntt_gf64_rdx2_col.sv
verilog/ntt_gf64_ntw_cst.sv
verilog/ntt_gf64_core.sv
tests/ntt_gf64_core_sva.sv
tests/ntt_gf64_core_tb.sv

// ==== tests/ntt_gf64_core_sva.sv ====
/*
  Assertions on the NTT core, bound to the top level.
  Quiet output after reset, fixed avail latency, reduced outputs.
*/
`timescale 1ns/1ps

module ntt_gf64_core_sva
  import ntt_gf64_pkg::*;
(
  input logic clk,
  input logic s_rst_n,
  input logic in_avail,
  input logic out_avail,
  input vec_t out_data
);

  localparam int LAT = 8;

  // Tally of failed assertions
  int n_fail = 0;

  // No output during reset and while the flushed pipe refills
  a_rst_quiet: assert property (@(posedge clk)
    !s_rst_n |=> !out_avail [*LAT])
  else begin
    $error("out_avail high within %0d cycles of a reset", LAT);
    n_fail++;
  end

  // Once out of reset long enough, avail is a pure delay line
  a_avail_lat: assert property (@(posedge clk)
    s_rst_n [*LAT+1] |-> out_avail == $past(in_avail, LAT))
  else begin
    $error("out_avail does not follow in_avail by %0d cycles", LAT);
    n_fail++;
  end

  // Every valid lane is a reduced field element
  for (genvar j = 0; j < N; j++) begin : gen_range
    a_lane_range: assert property (@(posedge clk) disable iff (!s_rst_n)
      out_avail |-> out_data[j] < MOD_P)
    else begin
      $error("out_data lane %0d is not below the modulus", j);
      n_fail++;
    end
  end

endmodule

bind ntt_gf64_core ntt_gf64_core_sva u_sva (
  .clk       (clk),
  .s_rst_n   (s_rst_n),
  .in_avail  (in_avail),
  .out_avail (out_avail),
  .out_data  (out_data)
);

// ==== tests/ntt_gf64_core_tb.sv ====
/*
  Testbench of the 8-point Goldilocks NTT core.
  Clock and reset, random stimulus from a fixed seed, a reference
  transform in 128-bit modular arithmetic, lane by lane checks of
  data and ctrl, a cycle limit and the closing report.
*/
`timescale 1ns/1ps

module ntt_gf64_core_tb
  import ntt_gf64_pkg::*;
();

  localparam int LAT     = 8;
  localparam int RST_CYC = 4;
  localparam int N_IMP   = 2;
  localparam int N_RAND  = 200;
  localparam int N_EDGE  = 20;
  localparam int N_GAP   = 80;
  localparam int N_PRE   = 10;
  localparam int N_RST   = 3;
  localparam int N_POST  = 20;
  // All phases, a few drains of the pipe, margin
  localparam int MAX_CYC = RST_CYC + N_IMP + N_RAND + N_EDGE + N_GAP
                         + N_PRE + N_RST + N_POST + 4*LAT + 30;

  logic  clk;
  logic  s_rst_n;
  vec_t  in_data;
  logic  in_avail;
  ctrl_t in_ctrl;
  vec_t  out_data;
  logic  out_avail;
  ctrl_t out_ctrl;

  // Accepted inputs waiting for their result
  vec_t  in_q   [$];
  ctrl_t ctrl_q [$];

  int n_err   = 0;
  int n_chk   = 0;
  int n_sent  = 0;
  int n_in    = 0;
  int n_out   = 0;
  int n_flush = 0;
  int cyc     = 0;

  ntt_gf64_core #(
    .IN_PIPE  (1'b0),
    .OUT_PIPE (1'b1)
  ) ntt_gf64_core_i (
    .clk       (clk),
    .s_rst_n   (s_rst_n),
    .in_data   (in_data),
    .in_avail  (in_avail),
    .in_ctrl   (in_ctrl),
    .out_data  (out_data),
    .out_avail (out_avail),
    .out_ctrl  (out_ctrl)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------
  // Three index bits read back to front
  function automatic int bitrev3(int v);
    int r;
    r = 0;
    for (int b = 0; b < 3; b++) begin
      r = (r << 1) | ((v >> b) & 1);
    end
    return r;
  endfunction

  function automatic elem_t mul_mod(elem_t a, elem_t b);
    logic [127:0] prod;
    prod = {64'd0, a} * {64'd0, b};
    return elem_t'(prod % {64'd0, MOD_P});
  endfunction

  function automatic elem_t add_mod(elem_t a, elem_t b);
    logic [127:0] s;
    s = {64'd0, a} + {64'd0, b};
    return elem_t'(s % {64'd0, MOD_P});
  endfunction

  // X[k] = sum of x[n] * w^(n*k) with w = 2^24 goes to lane bitrev3(k)
  function automatic vec_t ntt_model(vec_t x);
    vec_t  y;
    elem_t root;
    elem_t wk;
    elem_t tw;
    elem_t acc;
    root = elem_t'(1) << ROOT_EXP;
    for (int k = 0; k < N; k++) begin
      wk = 64'd1;
      for (int i = 0; i < k; i++) begin
        wk = mul_mod(wk, root);
      end
      acc = 64'd0;
      tw  = 64'd1;
      for (int n = 0; n < N; n++) begin
        acc = add_mod(acc, mul_mod(x[n], tw));
        tw  = mul_mod(tw, wk);
      end
      y[bitrev3(k)] = acc;
    end
    return y;
  endfunction

  // ------------------------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------------------------
  function automatic vec_t rand_vec();
    vec_t v;
    for (int i = 0; i < N; i++) begin
      v[i] = {$urandom, $urandom};
      // Rare values at or above p folded back
      if (v[i] >= MOD_P)
        v[i] = v[i] - MOD_P;
    end
    return v;
  endfunction

  // Lanes near the wraparound points of add, sub and shift reduction
  function automatic vec_t edge_vec();
    vec_t v;
    for (int i = 0; i < N; i++) begin
      case ($urandom % 5)
        0:       v[i] = MOD_P - 64'd1;
        1:       v[i] = MOD_P - 64'h1_0000_0000;
        2:       v[i] = 64'h1_0000_0000;
        3:       v[i] = 64'd0;
        default: v[i] = 64'd1;
      endcase
    end
    return v;
  endfunction

  task automatic send(vec_t v);
    @(posedge clk);
    in_data  <= v;
    in_avail <= 1'b1;
    in_ctrl  <= ctrl_t'(8'($urandom));
    n_sent++;
  endtask

  // Data toggles while avail is low and must be ignored
  task automatic idle(int cycles);
    repeat (cycles) begin
      @(posedge clk);
      in_avail <= 1'b0;
      in_data  <= rand_vec();
    end
  endtask

  task automatic drain();
    @(posedge clk);
    in_avail <= 1'b0;
    // Queue is read away from the clock edge
    do
      @(negedge clk);
    while (in_q.size() != 0);
  endtask

  // ------------------------------------------------------------------
  // Checks and report
  // ------------------------------------------------------------------
  task automatic compare(string name, logic [63:0] exp, logic [63:0] act);
    n_chk++;
    if (act !== exp) begin
      n_err++;
      $display("Fail %s: expected 0x%h, got 0x%h (cycle %0d)", name, exp, act, cyc);
    end
  endtask

  task automatic finish_run();
    int total;
    total = n_err + ntt_gf64_core_i.u_sva.n_fail;
    $display("checks %0d, errors %0d, assertion failures %0d, in %0d, out %0d, flushed %0d",
             n_chk, n_err, ntt_gf64_core_i.u_sva.n_fail, n_in, n_out, n_flush);
    if (total == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  endtask

  // Pairs each output with the oldest accepted input
  always @(posedge clk) begin : monitor
    vec_t  exp_v;
    ctrl_t exp_c;
    if (!s_rst_n) begin
      // Reset flushes whatever is in flight
      n_flush += in_q.size();
      in_q.delete();
      ctrl_q.delete();
    end else begin
      if (out_avail) begin
        if (in_q.size() == 0) begin
          n_err++;
          $display("Output vector at cycle %0d has no matching input", cyc);
        end else begin
          exp_v = ntt_model(in_q.pop_front());
          exp_c = ctrl_q.pop_front();
          n_out++;
          for (int j = 0; j < N; j++) begin
            compare($sformatf("out_data[%0d]", j), exp_v[j], out_data[j]);
          end
          compare("out_ctrl", 64'(exp_c), 64'(out_ctrl));
        end
      end
      if (in_avail) begin
        in_q.push_back(in_data);
        ctrl_q.push_back(in_ctrl);
        n_in++;
      end
    end
  end

  always @(posedge clk) begin : watchdog
    cyc <= cyc + 1;
    if (cyc >= MAX_CYC) begin
      n_err++;
      $display("Run stopped at the cycle limit %0d, outputs still missing", MAX_CYC);
      finish_run();
    end
  end

  // ------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------
  initial begin : stimulus
    vec_t v;
    void'($urandom(39));
    s_rst_n  = 1'b0;
    in_avail = 1'b0;
    in_data  = '0;
    in_ctrl  = '0;
    repeat (RST_CYC) @(posedge clk);
    s_rst_n <= 1'b1;

    // Impulses at x[0] and x[1]
    v    = '0;
    v[0] = 64'd1;
    send(v);
    v    = '0;
    v[1] = 64'd1;
    send(v);

    // Back to back random vectors
    for (int i = 0; i < N_RAND; i++) begin
      send(rand_vec());
    end

    for (int i = 0; i < N_EDGE; i++) begin
      send(edge_vec());
    end

    // Random gaps in avail
    for (int i = 0; i < N_GAP; i++) begin
      if ($urandom % 2)
        send(rand_vec());
      else
        idle(1);
    end
    drain();

    // Reset with vectors in flight and inputs still arriving
    for (int i = 0; i < N_PRE; i++) begin
      send(rand_vec());
    end
    for (int i = 0; i < N_RST; i++) begin
      send(rand_vec());
      s_rst_n <= 1'b0;
    end
    for (int i = 0; i < N_POST; i++) begin
      send(rand_vec());
      s_rst_n <= 1'b1;
    end
    drain();

    // Spurious outputs would show up here
    idle(LAT + 2);
    // Sends under reset never enter and the last LAT accepted before it are flushed
    compare("out_count", 64'(n_sent - N_RST - LAT), 64'(n_out));
    finish_run();
  end

endmodule

// ==== verilog/gf64_mod_add_sub.sv ====
/*
  Modular sum and difference of two reduced Goldilocks elements.
  One register stage on both results.
*/
`timescale 1ns/1ps

module gf64_mod_add_sub
  import ntt_gf64_pkg::*;
(
  input  logic  clk,
  input  elem_t a,
  input  elem_t b,
  output elem_t sum,
  output elem_t diff
);

  // ------------------------------------------------------------------
  // Combinational add and subtract
  // ------------------------------------------------------------------
  // One spare bit for carry and borrow
  logic [OP_W:0] sum_full;
  logic [OP_W:0] diff_full;
  logic [OP_W:0] sum_red;
  logic [OP_W:0] diff_red;

  assign sum_full  = {1'b0, a} + {1'b0, b};
  assign diff_full = {1'b0, a} - {1'b0, b};

  // Sum of two reduced values is below 2p
  assign sum_red = (sum_full >= {1'b0, MOD_P}) ? sum_full - {1'b0, MOD_P}
                                               : sum_full;

  // Borrow out in the top bit, add p back
  assign diff_red = diff_full[OP_W] ? diff_full + {1'b0, MOD_P}
                                    : diff_full;

  // ------------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    sum  <= sum_red[OP_W-1:0];
    diff <= diff_red[OP_W-1:0];
  end

endmodule

// ==== verilog/gf64_pow2_mult.sv ====
/*
  Multiply of a reduced Goldilocks element by 2^shift.
  Shift, split into 32-bit limbs, fold with 2^64 = 2^32 - 1 and
  2^96 = -1, then a short chain of conditional subtractions.
  One register stage on the result.
*/
`timescale 1ns/1ps

module gf64_pow2_mult
  import ntt_gf64_pkg::*;
(
  input  logic               clk,
  input  elem_t              x,
  input  logic [SHIFT_W-1:0] shift,
  output elem_t              y
);

  // Wide enough for x * 2^95
  localparam int PROD_W = 160;
  // Folded value stays below 8p
  localparam int ACC_W  = 67;

  localparam logic [ACC_W-1:0] P1 = ACC_W'(MOD_P);
  localparam logic [ACC_W-1:0] P2 = ACC_W'(MOD_P) << 1;
  localparam logic [ACC_W-1:0] P4 = ACC_W'(MOD_P) << 2;

  logic [PROD_W-1:0] prod;
  logic [31:0]       l0, l1, l2, l3, l4;
  logic [ACC_W-1:0]  pos;
  logic [ACC_W-1:0]  neg;
  logic [ACC_W-1:0]  acc;
  logic [ACC_W-1:0]  red4;
  logic [ACC_W-1:0]  red2;
  logic [ACC_W-1:0]  red1;

  // ------------------------------------------------------------------
  // Shift and limb split
  // ------------------------------------------------------------------
  assign prod = {{(PROD_W-OP_W){1'b0}}, x} << shift;

  assign l0 = prod[31:0];
  assign l1 = prod[63:32];
  assign l2 = prod[95:64];
  assign l3 = prod[127:96];
  assign l4 = prod[159:128];

  // ------------------------------------------------------------------
  // Fold
  // ------------------------------------------------------------------
  // l2*2^64 -> l2*2^32 - l2
  // l3*2^96 -> -l3
  // l4*2^128 -> -l4*2^32
  assign pos = ACC_W'(l0) + ((ACC_W'(l1) + ACC_W'(l2)) << 32);
  assign neg = ACC_W'(l2) + ACC_W'(l3) + (ACC_W'(l4) << 32);

  // neg is below 2p, so the offset keeps acc positive
  assign acc = pos + P2 - neg;

  // Binary chain of corrections, acc < 8p
  assign red4 = (acc  >= P4) ? acc  - P4 : acc;
  assign red2 = (red4 >= P2) ? red4 - P2 : red4;
  assign red1 = (red2 >= P1) ? red2 - P1 : red2;

  // ------------------------------------------------------------------
  // Output register
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    y <= red1[OP_W-1:0];
  end

endmodule

// ==== verilog/ntt_gf64_core.sv ====
/*
  Fully parallel 8-point forward NTT over the Goldilocks field.
  Three butterfly columns joined by two hardwired networks.
  Natural order in, bit-reversed order out, 8 cycles of latency.
*/
`timescale 1ns/1ps

module ntt_gf64_core
  import ntt_gf64_pkg::*;
#(
  parameter bit IN_PIPE  = 1'b0,
  parameter bit OUT_PIPE = 1'b1
)
(
  input  logic  clk,
  input  logic  s_rst_n,
  input  vec_t  in_data,
  input  logic  in_avail,
  input  ctrl_t in_ctrl,
  output vec_t  out_data,
  output logic  out_avail,
  output ctrl_t out_ctrl
);

  vec_t  col_in_data   [N_COL];
  logic  col_in_avail  [N_COL];
  ctrl_t col_in_ctrl   [N_COL];
  vec_t  col_out_data  [N_COL];
  logic  col_out_avail [N_COL];
  ctrl_t col_out_ctrl  [N_COL];

  // ------------------------------------------------------------------
  // Input lane order
  // ------------------------------------------------------------------
  // First column pairs x[n] with x[n+4], reached by 3-bit reversal
  for (genvar l = 0; l < N; l++) begin : gen_in_perm
    localparam int SRC = ((l & 1) << 2) | (l & 2) | ((l >> 2) & 1);
    assign col_in_data[0][l] = in_data[SRC];
  end

  assign col_in_avail[0] = in_avail;
  assign col_in_ctrl[0]  = in_ctrl;

  // ------------------------------------------------------------------
  // Columns and networks
  // ------------------------------------------------------------------
  for (genvar c = 0; c < N_COL; c++) begin : gen_col
    ntt_gf64_rdx2_col #(
      .COL_ID (c)
    ) u_col (
      .clk       (clk),
      .s_rst_n   (s_rst_n),
      .in_data   (col_in_data[c]),
      .in_avail  (col_in_avail[c]),
      .in_ctrl   (col_in_ctrl[c]),
      .out_data  (col_out_data[c]),
      .out_avail (col_out_avail[c]),
      .out_ctrl  (col_out_ctrl[c])
    );

    // Network after every column but the last
    if (c < N_COL-1) begin : gen_ntw
      ntt_gf64_ntw_cst #(
        .RDX_CUT_ID (c+1),
        .IN_PIPE    (IN_PIPE),
        .OUT_PIPE   (OUT_PIPE)
      ) u_ntw (
        .clk       (clk),
        .s_rst_n   (s_rst_n),
        .in_data   (col_out_data[c]),
        .in_avail  (col_out_avail[c]),
        .in_ctrl   (col_out_ctrl[c]),
        .out_data  (col_in_data[c+1]),
        .out_avail (col_in_avail[c+1]),
        .out_ctrl  (col_in_ctrl[c+1])
      );
    end
  end

  assign out_data  = col_out_data[N_COL-1];
  assign out_avail = col_out_avail[N_COL-1];
  assign out_ctrl  = col_out_ctrl[N_COL-1];

endmodule

// ==== verilog/ntt_gf64_ntw_cst.sv ====
/*
  Hardwired network between two butterfly columns.
  Transposes each group of R_L x L_NB lanes so that the next
  column finds its butterfly partners on adjacent lanes.
  Optional register stages before and after the wiring.
*/
`timescale 1ns/1ps

`include "ntt_gf64_ntw_macro.svh"

module ntt_gf64_ntw_cst
  import ntt_gf64_pkg::*;
#(
  // Column that precedes this network plus one
  parameter int RDX_CUT_ID = 1,
  parameter bit IN_PIPE    = 1'b0,
  parameter bit OUT_PIPE   = 1'b1
)
(
  input  logic  clk,
  input  logic  s_rst_n,
  input  vec_t  in_data,
  input  logic  in_avail,
  input  ctrl_t in_ctrl,
  output vec_t  out_data,
  output logic  out_avail,
  output ctrl_t out_ctrl
);

  `NTT_GF64_NTW_LOCALPARAM(RDX_CUT_ID, R, N)

  vec_t  s0_data;
  logic  s0_avail;
  ctrl_t s0_ctrl;

  // ------------------------------------------------------------------
  // Input stage
  // ------------------------------------------------------------------
  if (IN_PIPE) begin : gen_in_pipe
    always_ff @(posedge clk) begin
      if (!s_rst_n) s0_avail <= 1'b0;
      else          s0_avail <= in_avail;
    end

    always_ff @(posedge clk) begin
      s0_data <= in_data;
      s0_ctrl <= in_ctrl;
    end
  end else begin : gen_in_wire
    assign s0_data  = in_data;
    assign s0_avail = in_avail;
    assign s0_ctrl  = in_ctrl;
  end

  // ------------------------------------------------------------------
  // Transpose
  // ------------------------------------------------------------------
  // Group view [wb][r][l] in, [wb][l][r] out
  elem_t [WB_NB-1:0][R_L-1:0][L_NB-1:0] s0_grp;
  elem_t [WB_NB-1:0][L_NB-1:0][R_L-1:0] s0_disp;

  assign s0_grp = s0_data;

  always_comb begin
    for (int w = 0; w < WB_NB; w++)
      for (int l = 0; l < L_NB; l++)
        for (int r = 0; r < R_L; r++)
          s0_disp[w][l][r] = s0_grp[w][r][l];
  end

  // ------------------------------------------------------------------
  // Output stage
  // ------------------------------------------------------------------
  if (OUT_PIPE) begin : gen_out_pipe
    always_ff @(posedge clk) begin
      if (!s_rst_n) out_avail <= 1'b0;
      else          out_avail <= s0_avail;
    end

    always_ff @(posedge clk) begin
      out_data <= s0_disp;
      out_ctrl <= s0_ctrl;
    end
  end else begin : gen_out_wire
    assign out_data  = s0_disp;
    assign out_avail = s0_avail;
    assign out_ctrl  = s0_ctrl;
  end

endmodule

// ==== verilog/ntt_gf64_pkg.sv ====
/*
  Shared constants and types of the 8-point Goldilocks NTT.
  Field modulus, transform geometry, twiddle root exponent,
  element and vector types, and the control group that travels
  with every vector.
*/
package ntt_gf64_pkg;

  // ------------------------------------------------------------------
  // Field
  // ------------------------------------------------------------------
  // Goldilocks prime 2^64 - 2^32 + 1
  localparam logic [63:0] MOD_P = 64'hFFFF_FFFF_0000_0001;
  localparam int          OP_W  = 64;

  // ------------------------------------------------------------------
  // Transform geometry
  // ------------------------------------------------------------------
  localparam int N     = 8;
  localparam int R     = 2;
  // Butterflies per column
  localparam int PSI   = N / R;
  localparam int N_COL = 3;

  // 2^24 is a primitive 8th root of unity mod p
  localparam int ROOT_EXP = 24;
  // Twiddle shift width, largest exponent used is 3*ROOT_EXP
  localparam int SHIFT_W  = 7;

  // ------------------------------------------------------------------
  // Types
  // ------------------------------------------------------------------
  localparam int BATCH_ID_W = 4;

  typedef logic [OP_W-1:0] elem_t;

  // Lane 0 in the low bits
  typedef elem_t [N-1:0] vec_t;

  // Framing flags and batch tag
  typedef struct packed {
    logic                  sob;
    logic                  eob;
    logic                  sol;
    logic                  eol;
    logic [BATCH_ID_W-1:0] batch_id;
  } ctrl_t;

endpackage

// ==== verilog/ntt_gf64_rdx2_col.sv ====
/*
  One column of four radix-2 DIF butterflies.
  Butterfly b works on lanes 2b and 2b+1: sum on the upper lane,
  difference times the column twiddle on the lower lane.
  Two cycles of latency, avail and ctrl delayed to match.
*/
`timescale 1ns/1ps

module ntt_gf64_rdx2_col
  import ntt_gf64_pkg::*;
#(
  parameter int COL_ID = 0
)
(
  input  logic  clk,
  input  logic  s_rst_n,
  input  vec_t  in_data,
  input  logic  in_avail,
  input  ctrl_t in_ctrl,
  output vec_t  out_data,
  output logic  out_avail,
  output ctrl_t out_ctrl
);

  // ------------------------------------------------------------------
  // Twiddle exponents
  // ------------------------------------------------------------------
  // Column 0 pair index holds the 2-bit reversed input row,
  // column 1 has the odd/even bit of the row on bit 1,
  // last column needs no twiddle
  function automatic logic [SHIFT_W-1:0] tw_exp(input int col, input int bfly);
    int row;
    row = ((bfly & 1) << 1) | ((bfly >> 1) & 1);
    case (col)
      0:       return SHIFT_W'(ROOT_EXP * row);
      1:       return SHIFT_W'(2 * ROOT_EXP * ((bfly >> 1) & 1));
      default: return '0;
    endcase
  endfunction

  vec_t as_data;
  logic avail_q1;
  logic avail_q2;
  ctrl_t ctrl_q1;
  ctrl_t ctrl_q2;

  // ------------------------------------------------------------------
  // Butterflies
  // ------------------------------------------------------------------
  for (genvar b = 0; b < PSI; b++) begin : gen_bfly
    gf64_mod_add_sub u_add_sub (
      .clk  (clk),
      .a    (in_data[R*b]),
      .b    (in_data[R*b+1]),
      .sum  (as_data[R*b]),
      .diff (as_data[R*b+1])
    );

    // Unit shift on the sum lane keeps both lanes aligned
    gf64_pow2_mult u_mult_up (
      .clk   (clk),
      .x     (as_data[R*b]),
      .shift ('0),
      .y     (out_data[R*b])
    );

    gf64_pow2_mult u_mult_lo (
      .clk   (clk),
      .x     (as_data[R*b+1]),
      .shift (tw_exp(COL_ID, b)),
      .y     (out_data[R*b+1])
    );
  end

  // ------------------------------------------------------------------
  // Side band delay
  // ------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      avail_q1 <= 1'b0;
      avail_q2 <= 1'b0;
    end else begin
      avail_q1 <= in_avail;
      avail_q2 <= avail_q1;
    end
  end

  always_ff @(posedge clk) begin
    ctrl_q1 <= in_ctrl;
    ctrl_q2 <= ctrl_q1;
  end

  assign out_avail = avail_q2;
  assign out_ctrl  = ctrl_q2;

endmodule
